/* vlog.f */
verilog/dpram_pkg.sv
verilog/dual_port_ram.sv
verilog/button_decoder.sv
verilog/board_fsm.sv
verilog/dpram_board.sv
tb/board_fsm_assert.sv
tb/dpram_board_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS = --timing --assert
TOP = dpram_board_tb
FILELIST = vlog.f
OBJ_DIR = obj_dir
LOG = sim.log
PASS_TEXT = No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_TEXT)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/dpram_board_tb.sv */
`timescale 1ns/1ps

module dpram_board_tb;

	typedef struct packed {
		logic [2:0] buttons;
		dpram_pkg::op_t expect_op;
		logic [3:0] hold; // zero picks a random hold length.
		logic check;
		logic busy_press;
	} row_t;

	logic clk;
	logic reset;
	logic [2:0] button_code;
	dpram_pkg::addr_t display_addr;
	dpram_pkg::word_t display_out;
	logic busy;
	logic [31:0] rng;
	dpram_pkg::word_t model [dpram_pkg::ram_depth] = '{default: '0};
	dpram_pkg::addr_t set_list [12] = '{10'd0, 10'd1, 10'd2, 10'd3, 10'd4, 10'd5,
		10'd504, 10'd505, 10'd506, 10'd507, 10'd508, 10'd509};

	row_t rows [11] = '{
		'{3'b001, dpram_pkg::op_load, 4'd2, 1'b1, 1'b0},
		'{3'b010, dpram_pkg::op_increment, 4'd0, 1'b0, 1'b0},
		'{3'b010, dpram_pkg::op_increment, 4'd3, 1'b1, 1'b0},
		'{3'b001, dpram_pkg::op_load, 4'd1, 1'b1, 1'b0},
		'{3'b100, dpram_pkg::op_fibonacci, 4'd2, 1'b1, 1'b0},
		'{3'b100, dpram_pkg::op_fibonacci, 4'd0, 1'b1, 1'b0},
		'{3'b100, dpram_pkg::op_fibonacci, 4'd4, 1'b1, 1'b0},
		'{3'b110, dpram_pkg::op_increment, 4'd2, 1'b1, 1'b0}, // lower button wins.
		'{3'b111, dpram_pkg::op_load, 4'd0, 1'b1, 1'b0},
		'{3'b010, dpram_pkg::op_increment, 4'd1, 1'b1, 1'b1},
		'{3'b100, dpram_pkg::op_fibonacci, 4'd0, 1'b1, 1'b0}
	};

	dpram_board i_dut (
		.clk(clk),
		.reset(reset),
		.button_code(button_code),
		.display_addr(display_addr),
		.display_out(display_out),
		.busy(busy)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic dpram_pkg::addr_t outside_addr(input logic [31:0] r);
		dpram_pkg::addr_t a;
		a = dpram_pkg::addr_t'(r);
		if (a < 10'd6 || (a >= 10'd504 && a < 10'd510))
			a = a + 10'd12; // steps clear of either block.
		return a;
	endfunction

	task automatic report_failure();
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input dpram_pkg::word_t got,
		input dpram_pkg::word_t exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
			report_failure();
		end
	endtask

	task automatic check_busy(input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch busy: got %h, expected %h", got, exp);
			report_failure();
		end
	endtask

	// the ram registers the address on the first edge, the word is valid after the second.
	task automatic check_display(input dpram_pkg::addr_t addr, input dpram_pkg::word_t exp);
		@(posedge clk);
		display_addr <= addr;
		@(posedge clk);
		@(negedge clk);
		check_word($sformatf("display_out at %h", addr), display_out, exp);
	endtask

	task automatic check_block();
		logic [3:0] k;
		for (k = 0; k < 4'd12; k++)
			check_display(set_list[k], model[set_list[k]]);
		rng = xorshift(rng);
		check_display(outside_addr(rng), '0);
	endtask

	task automatic apply_model(input dpram_pkg::op_t op);
		logic [3:0] k;
		dpram_pkg::word_t sum;
		case (op)
		dpram_pkg::op_load: begin
			for (k = 0; k < 4'd12; k++)
				model[set_list[k]] = dpram_pkg::word_t'(set_list[k]);
		end
		dpram_pkg::op_increment: begin
			for (k = 0; k < 4'd12; k++)
				model[set_list[k]] = model[set_list[k]] + 16'd1;
		end
		default: begin
			sum = model[0] + model[1];
			model[0] = model[1];
			model[1] = sum;
			model[2] = sum;
		end
		endcase
	endtask

	task automatic wait_busy_rise();
		int n;
		n = 0;
		while (!busy && n < 5) begin
			@(negedge clk);
			n++;
		end
		if (!busy) begin
			$display("busy did not rise within 4 cycles of the button release.");
			report_failure();
		end
	endtask

	task automatic wait_busy_fall();
		int n;
		n = 0;
		@(negedge clk);
		while (busy && n < 64) begin
			check_word("display_out while busy", display_out, '0);
			@(negedge clk);
			n++;
		end
		if (busy) begin
			$display("busy stayed high for more than 64 cycles.");
			report_failure();
		end
	endtask

	task automatic run_row(input row_t row);
		int hold;
		hold = int'(row.hold);
		if (hold == 0) begin
			rng = xorshift(rng);
			hold = 1 + int'(rng % 32'd4);
		end
		@(posedge clk);
		button_code <= row.buttons;
		repeat (hold) @(posedge clk);
		button_code <= '0;
		wait_busy_rise();
		if (row.busy_press) begin
			@(posedge clk);
			button_code <= 3'b100; // lands mid-operation and must be dropped.
			repeat (2) @(posedge clk);
			button_code <= '0;
		end
		wait_busy_fall();
		apply_model(row.expect_op);
		repeat (2) @(posedge clk);
		@(negedge clk);
		check_busy(busy, 1'b0);
		if (row.check)
			check_block();
		@(negedge clk);
		check_busy(busy, 1'b0);
	endtask

	// each check sees the word for the address driven one edge earlier.
	task automatic sweep_display(input int count);
		int i;
		dpram_pkg::addr_t prev;
		dpram_pkg::addr_t next;
		rng = xorshift(rng);
		prev = dpram_pkg::addr_t'(rng);
		@(posedge clk);
		display_addr <= prev;
		for (i = 0; i < count; i++) begin
			rng = xorshift(rng);
			if (i % 2 == 0)
				next = set_list[4'(rng % 32'd12)];
			else
				next = dpram_pkg::addr_t'(rng);
			@(posedge clk);
			display_addr <= next;
			@(negedge clk);
			check_word($sformatf("display_out at %h", prev), display_out, model[prev]);
			prev = next;
		end
	endtask

	initial begin
		logic [3:0] r;
		clk = 1'b0;
		reset = 1'b1;
		button_code = '0;
		display_addr = '0;
		rng = 32'h6e65_55b3;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		check_busy(busy, 1'b0);
		check_display('0, '0);
		rng = xorshift(rng);
		check_display(outside_addr(rng), '0);
		for (r = 0; r < 4'd11; r++)
			run_row(rows[r]);
		sweep_display(24);
		$display("No errors");
		$finish;
	end

endmodule

/* tb/board_fsm_assert.sv */
`timescale 1ns/1ps

module board_fsm_assert (
	input logic clk,
	input logic reset,
	input logic req,
	input logic ack,
	input dpram_pkg::port_req_t port_a,
	input dpram_pkg::port_req_t port_b
);

	// the decoder holds its request until the controller answers.
	req_held: assert property (@(posedge clk) disable iff (reset)
		req && !ack |=> req)
		else $error("req dropped before ack was raised.");

	ack_held: assert property (@(posedge clk) disable iff (reset)
		ack && req |=> ack)
		else $error("ack dropped while req was still high.");

	// writes come only from a running operation and never hit one word from both ports.
	no_idle_write: assert property (@(posedge clk) disable iff (reset)
		port_a.wen || port_b.wen |-> ack
			&& !(port_a.wen && port_b.wen && port_a.addr == port_b.addr))
		else $error("a ram write came outside an operation or hit one address twice.");

endmodule

bind board_fsm board_fsm_assert i_assert (
	.clk(clk),
	.reset(reset),
	.req(req),
	.ack(ack),
	.port_a(port_a),
	.port_b(port_b)
);

/* verilog/dpram_board.sv */
`timescale 1ns/1ps

module dpram_board (
	input logic clk,
	input logic reset,
	input logic [2:0] button_code,
	input dpram_pkg::addr_t display_addr,
	output dpram_pkg::word_t display_out,
	output logic busy
);

	logic req;
	logic ack;
	dpram_pkg::op_t op;
	dpram_pkg::port_req_t port_a;
	dpram_pkg::port_req_t port_b;
	dpram_pkg::word_t dout_a;
	dpram_pkg::word_t dout_b;

	button_decoder u_decoder (
		.clk(clk),
		.reset(reset),
		.button_code(button_code),
		.ack(ack),
		.req(req),
		.op(op)
	);

	board_fsm u_fsm (
		.clk(clk),
		.reset(reset),
		.req(req),
		.op(op),
		.ack(ack),
		.display_addr(display_addr),
		.display_out(display_out),
		.port_a(port_a),
		.port_b(port_b),
		.dout_a(dout_a),
		.dout_b(dout_b)
	);

	dual_port_ram u_ram (
		.clk(clk),
		.port_a(port_a),
		.port_b(port_b),
		.dout_a(dout_a),
		.dout_b(dout_b)
	);

	assign busy = ack;

endmodule

/* verilog/board_fsm.sv */
`timescale 1ns/1ps

module board_fsm (
	input logic clk,
	input logic reset,
	input logic req,
	input dpram_pkg::op_t op,
	output logic ack,
	input dpram_pkg::addr_t display_addr,
	output dpram_pkg::word_t display_out,
	output dpram_pkg::port_req_t port_a,
	output dpram_pkg::port_req_t port_b,
	input dpram_pkg::word_t dout_a,
	input dpram_pkg::word_t dout_b
);

	typedef enum logic [1:0] {
		st_idle,
		st_run,
		st_done
	} state_t;

	state_t state;
	logic [4:0] step;
	logic [4:0] last_step;
	dpram_pkg::op_t cur_op;
	dpram_pkg::addr_t pair_lo;
	dpram_pkg::addr_t pair_hi;
	dpram_pkg::addr_t inc_addr;

	// maps an index 0 to 11 onto the low block followed by the high block.
	function automatic dpram_pkg::addr_t set_addr(input logic [3:0] index);
		if (index < 4'(dpram_pkg::block_len))
			return dpram_pkg::addr_t'(dpram_pkg::low_base) + dpram_pkg::addr_t'(index);
		return dpram_pkg::addr_t'(dpram_pkg::high_base)
			+ dpram_pkg::addr_t'(index - 4'(dpram_pkg::block_len));
	endfunction

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= st_idle;
			step <= '0;
		end else begin
			case (state)
			st_idle: begin
				step <= '0;
				if (req)
					state <= st_run;
			end
			st_run: begin
				step <= step + 5'd1;
				if (step == last_step)
					state <= st_done; // the last write lands on this edge.
			end
			st_done: begin
				if (!req)
					state <= st_idle;
			end
			default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle && req)
			cur_op <= op;
	end

	// ack spans the whole operation plus the wait for req to drop.
	assign ack = (state != st_idle);

	always_comb begin
		case (cur_op)
		dpram_pkg::op_load: last_step = 5'(dpram_pkg::block_len - 1);
		dpram_pkg::op_increment: last_step = 5'(4 * dpram_pkg::block_len - 1);
		default: last_step = 5'd3;
		endcase
	end

	// load fills two neighbours per cycle; increment spends two cycles per word.
	assign pair_lo = set_addr({step[2:0], 1'b0});
	assign pair_hi = set_addr({step[2:0], 1'b1});
	assign inc_addr = set_addr(step[4:1]);

	always_comb begin
		port_a = '0;
		port_b = '0;
		port_a.addr = display_addr; // display read whenever nothing runs.
		if (state == st_run) begin
			case (cur_op)
			dpram_pkg::op_load: begin
				port_a.wen = 1'b1;
				port_a.addr = pair_lo;
				port_a.din = dpram_pkg::word_t'(pair_lo);
				port_b.wen = 1'b1;
				port_b.addr = pair_hi;
				port_b.din = dpram_pkg::word_t'(pair_hi);
			end
			dpram_pkg::op_increment: begin
				port_a.addr = inc_addr;
				port_a.wen = step[0]; // even steps read, odd steps write back.
				port_a.din = dout_a + dpram_pkg::word_t'(1);
			end
			default: begin
				case (step[1:0])
				2'd0: begin
					port_a.addr = set_addr(4'd0);
					port_b.addr = set_addr(4'd1);
				end
				2'd1: begin
					port_a.wen = 1'b1;
					port_a.addr = set_addr(4'd2);
					port_a.din = dout_a + dout_b;
				end
				2'd2: begin
					port_a.addr = set_addr(4'd1);
					port_b.addr = set_addr(4'd2);
				end
				default: begin
					// old mem[1] shifts down and the new sum moves into mem[1].
					port_a.wen = 1'b1;
					port_a.addr = set_addr(4'd0);
					port_a.din = dout_a;
					port_b.wen = 1'b1;
					port_b.addr = set_addr(4'd1);
					port_b.din = dout_b;
				end
				endcase
			end
			endcase
		end
	end

	// dout_a in idle answers the display read issued on the previous edge.
	assign display_out = (state == st_idle) ? dout_a : '0;

endmodule

/* verilog/button_decoder.sv */
`timescale 1ns/1ps

module button_decoder (
	input logic clk,
	input logic reset,
	input logic [2:0] button_code,
	input logic ack,
	output logic req,
	output dpram_pkg::op_t op
);

	typedef enum logic [1:0] {
		st_idle,
		st_armed,
		st_request,
		st_ack_wait
	} state_t;

	logic [2:0] sync_1;
	logic [2:0] sync_2;
	state_t state;

	// lowest-numbered pressed button wins.
	function automatic dpram_pkg::op_t pick_op(input logic [2:0] buttons);
		if (buttons[0])
			return dpram_pkg::op_load;
		else if (buttons[1])
			return dpram_pkg::op_increment;
		return dpram_pkg::op_fibonacci;
	endfunction

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			sync_1 <= '0;
			sync_2 <= '0;
		end else begin
			sync_1 <= button_code;
			sync_2 <= sync_1;
		end
	end

	// buttons are only looked at in idle, so presses during an operation are dropped.
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= st_idle;
			req <= 1'b0;
		end else begin
			case (state)
			st_idle: begin
				if (|sync_2)
					state <= st_armed;
			end
			st_armed: begin
				if (sync_2 == 3'b000) begin // the operation starts on release.
					req <= 1'b1;
					state <= st_request;
				end
			end
			st_request: begin
				if (ack) begin
					req <= 1'b0;
					state <= st_ack_wait;
				end
			end
			st_ack_wait: begin
				if (!ack)
					state <= st_idle;
			end
			default: state <= st_idle;
			endcase
		end
	end

	// op holds from the press until the controller has finished with it.
	always_ff @(posedge clk) begin
		if (state == st_idle && |sync_2)
			op <= pick_op(sync_2);
	end

endmodule

/* verilog/dual_port_ram.sv */
`timescale 1ns/1ps

module dual_port_ram (
	input logic clk,
	input dpram_pkg::port_req_t port_a,
	input dpram_pkg::port_req_t port_b,
	output dpram_pkg::word_t dout_a,
	output dpram_pkg::word_t dout_b
);

	// contents come up as zero and keep their value through reset.
	dpram_pkg::word_t mem [dpram_pkg::ram_depth] = '{default: '0};

	always_ff @(posedge clk) begin
		// port a is written last, so it wins when both ports hit one address.
		if (port_b.wen)
			mem[port_b.addr] <= port_b.din;
		if (port_a.wen)
			mem[port_a.addr] <= port_a.din;
	end

	// registered reads, write-first within each port.
	always_ff @(posedge clk) begin
		if (port_a.wen)
			dout_a <= port_a.din;
		else
			dout_a <= mem[port_a.addr];
	end

	always_ff @(posedge clk) begin
		if (port_b.wen)
			dout_b <= port_b.din;
		else
			dout_b <= mem[port_b.addr];
	end

endmodule

/* verilog/dpram_pkg.sv */
package dpram_pkg;

	// ram geometry.
	localparam int addr_w = 10;
	localparam int data_w = 16;
	localparam int ram_depth = 1024;

	// the twelve addresses every operation touches, as two blocks of six.
	localparam int low_base = 0;
	localparam int high_base = 504;
	localparam int block_len = 6;

	typedef logic [addr_w-1:0] addr_t;
	typedef logic [data_w-1:0] word_t;

	// button bit 0 maps to load, bit 1 to increment, bit 2 to fibonacci.
	typedef enum logic [1:0] {
		op_load,
		op_increment,
		op_fibonacci
	} op_t;

	// one request to a ram port.
	typedef struct packed {
		logic wen;
		addr_t addr;
		word_t din;
	} port_req_t;

endpackage
